// ==== Bender.yml ====
package:
  name: cart_mem

sources:
  # package first, then the blocks, top level last
  - files:
      - src/cart_pkg.sv
      - src/cart_header.sv
      - src/mbc1_mapper.sv
      - src/mem_arbiter.sv
      - src/word_ram.sv
      - src/cart_mem_top.sv

  - target: test
    files:
      - tb/cart_mem_tb.sv

// ==== filelist.f ====
src/cart_pkg.sv
src/cart_header.sv
src/mbc1_mapper.sv
src/mem_arbiter.sv
src/word_ram.sv
src/cart_mem_top.sv
tb/cart_mem_tb.sv

// ==== src/cart_header.sv ====
// cartridge header capture
// snoops download writes for the type and size bytes, derives bank masks
`timescale 1ns/1ps
`default_nettype none

module cart_header (
   input  logic                  clk64,
   input  logic                  reset,
   input  logic                  dl_active,
   input  logic                  dl_wr,
   input  cart_pkg::mem_addr_t   dl_addr,
   input  cart_pkg::word_t       dl_data,
   output cart_pkg::cart_hdr_t   hdr,
   output cart_pkg::cart_masks_t masks
);
   import cart_pkg::*;

   // header bytes, words are big endian so 0x148 is the high byte
   always_ff @(posedge clk64) begin
      if (reset) begin
         hdr <= '0;
      end else if (dl_active && dl_wr) begin
         if (dl_addr == HDR_TYPE_WORD) begin
            hdr.mbc_type <= dl_data[7:0];
         end
         if (dl_addr == HDR_SIZE_WORD) begin
            hdr.rom_size <= dl_data[15:8];
            hdr.ram_size <= dl_data[7:0];
         end
      end
   end

   // rom size code n means 2 << n banks of 16k
   always_comb begin
      case (hdr.rom_size)
         8'd0:    masks.rom_mask = 7'b0000001;
         8'd1:    masks.rom_mask = 7'b0000011;
         8'd2:    masks.rom_mask = 7'b0000111;
         8'd3:    masks.rom_mask = 7'b0001111;
         8'd4:    masks.rom_mask = 7'b0011111;
         8'd5:    masks.rom_mask = 7'b0111111;
         default: masks.rom_mask = 7'b1111111;
      endcase
   end

   // 2k and 8k parts have a single bank, everything else gets four
   assign masks.ram_mask = ((hdr.ram_size == 8'd1) || (hdr.ram_size == 8'd2)) ? 2'b00 : 2'b11;

   assign masks.mbc1 = (hdr.mbc_type >= MBC1_TYPE_FIRST) && (hdr.mbc_type <= MBC1_TYPE_LAST);

endmodule

`default_nettype wire

// ==== src/cart_mem_top.sv ====
// cartridge memory path top level
// header capture, MBC1 mapper, download arbiter and word memory
`timescale 1ns/1ps
`default_nettype none

module cart_mem_top (
   input  logic                 clk64,
   input  logic                 reset,
   // download port
   input  logic                 dl_active,
   input  logic                 dl_wr,
   input  cart_pkg::mem_addr_t  dl_addr,
   input  cart_pkg::word_t      dl_data,
   // cartridge port
   input  cart_pkg::cart_addr_t cart_addr,
   input  cart_pkg::byte_t      cart_di,
   input  logic                 cart_rd,
   input  logic                 cart_wr,
   output cart_pkg::byte_t      cart_do
);
   import cart_pkg::*;

   cart_masks_t masks;
   mem_req_t    cart_req;
   mem_req_t    mem_req;
   word_t       ram_dout;

   // header bytes picked out of the image stream
   cart_header header0 (
      .clk64     (clk64),
      .reset     (reset),
      .dl_active (dl_active),
      .dl_wr     (dl_wr),
      .dl_addr   (dl_addr),
      .dl_data   (dl_data),
      .hdr       (),
      .masks     (masks)
   );

   mbc1_mapper mapper0 (
      .clk64     (clk64),
      .reset     (reset),
      .dl_active (dl_active),
      .masks     (masks),
      .cart_addr (cart_addr),
      .cart_di   (cart_di),
      .cart_rd   (cart_rd),
      .cart_wr   (cart_wr),
      .ram_dout  (ram_dout),
      .cart_req  (cart_req),
      .cart_do   (cart_do)
   );

   // download has priority over the cpu
   mem_arbiter arbiter0 (
      .clk64     (clk64),
      .dl_active (dl_active),
      .dl_wr     (dl_wr),
      .dl_addr   (dl_addr),
      .dl_data   (dl_data),
      .cart_req  (cart_req),
      .mem_req   (mem_req)
   );

   word_ram ram0 (
      .clk64   (clk64),
      .mem_req (mem_req),
      .dout    (ram_dout)
   );

endmodule

`default_nettype wire

// ==== src/cart_pkg.sv ====
// cartridge memory path package
// widths, request and header structs, header word offsets and MBC1 mapping constants
`default_nettype none

package cart_pkg;

   // ------------------------------
   // widths with a meaning
   // ------------------------------
   typedef logic [7:0]  byte_t;
   typedef logic [15:0] word_t;
   typedef logic [15:0] cart_addr_t;
   // memory word address, full width of the external memory map
   typedef logic [23:0] mem_addr_t;
   // bank field above the 12 in-bank word bits
   typedef logic [8:0]  bank_t;
   // bit 1 selects the high byte, bit 0 the low byte
   typedef logic [1:0]  byte_lanes_t;

   localparam int ROM_BANK_BITS = 7;
   localparam int RAM_BANK_BITS = 2;

   // ------------------------------
   // structs
   // ------------------------------
   typedef struct packed {
      mem_addr_t   addr;
      word_t       wdata;
      byte_lanes_t lanes;
      logic        we;
      logic        rd;
   } mem_req_t;

   typedef struct packed {
      byte_t mbc_type;
      byte_t rom_size;
      byte_t ram_size;
   } cart_hdr_t;

   typedef struct packed {
      logic [ROM_BANK_BITS-1:0] rom_mask;
      logic [RAM_BANK_BITS-1:0] ram_mask;
      logic                     mbc1;
   } cart_masks_t;

   // ------------------------------
   // header and mapping constants
   // ------------------------------
   // image bytes 0x147 and 0x148/0x149 land in these words
   localparam mem_addr_t HDR_TYPE_WORD = 24'h0000a3;
   localparam mem_addr_t HDR_SIZE_WORD = 24'h0000a4;

   // word address bits that the on-chip memory decodes
   localparam int MEM_ADDR_BITS = 21;

   // cartridge RAM lives from bank 256 up
   localparam bank_t RAM_REGION_BANK = 9'd256;

   // mbc type codes that mean MBC1 (plain, +ram, +ram+battery)
   localparam byte_t MBC1_TYPE_FIRST = 8'h01;
   localparam byte_t MBC1_TYPE_LAST  = 8'h03;

   // cpu address regions by bits 15..13
   localparam logic [2:0] REGION_RAM_EN   = 3'd0;
   localparam logic [2:0] REGION_ROM_BANK = 3'd1;
   localparam logic [2:0] REGION_RAM_BANK = 3'd2;
   localparam logic [2:0] REGION_MODE     = 3'd3;
   localparam logic [2:0] REGION_CART_RAM = 3'd5;

   // low nibble that switches cartridge RAM on
   localparam logic [3:0] RAM_ENABLE_KEY = 4'ha;

   localparam byte_lanes_t LANES_BOTH = 2'b11;

endpackage

`default_nettype wire

// ==== src/mbc1_mapper.sv ====
// MBC1 mapper
// holds the bank, ram enable and mode registers, turns cpu addresses into
// memory word addresses and byte lanes, and picks the read byte
`timescale 1ns/1ps
`default_nettype none

module mbc1_mapper (
   input  logic                  clk64,
   input  logic                  reset,
   input  logic                  dl_active,
   input  cart_pkg::cart_masks_t masks,
   input  cart_pkg::cart_addr_t  cart_addr,
   input  cart_pkg::byte_t       cart_di,
   input  logic                  cart_rd,
   input  logic                  cart_wr,
   input  cart_pkg::word_t       ram_dout,
   output cart_pkg::mem_req_t    cart_req,
   output cart_pkg::byte_t       cart_do
);
   import cart_pkg::*;

   logic [2:0]               region;
   logic [4:0]               rom_bank_reg;
   logic [RAM_BANK_BITS-1:0] ram_bank_reg;
   logic                     ram_enable;
   logic                     mode;
   logic [ROM_BANK_BITS-1:0] rom_bank;
   logic [RAM_BANK_BITS-1:0] ram_bank;
   bank_t                    mbc1_bank;
   bank_t                    bank;
   logic                     a0_q;

   // 8k regions of the cpu cartridge window
   assign region = cart_addr[15:13];

   // ------------------------------
   // cpu register interface
   // ------------------------------
   // a running download also puts the mapper back to its power-up state
   always_ff @(posedge clk64) begin
      if (reset || dl_active) begin
         rom_bank_reg <= 5'd1;
         ram_bank_reg <= '0;
         ram_enable   <= 1'b0;
         mode         <= 1'b0;
      end else if (cart_wr) begin
         case (region)
            REGION_RAM_EN: begin
               ram_enable <= (cart_di[3:0] == RAM_ENABLE_KEY);
            end
            REGION_ROM_BANK: begin
               // bank 0 cannot be mapped into the upper window
               rom_bank_reg <= (cart_di[4:0] == 5'd0) ? 5'd1 : cart_di[4:0];
            end
            REGION_RAM_BANK: begin
               ram_bank_reg <= cart_di[1:0];
            end
            REGION_MODE: begin
               mode <= cart_di[0];
            end
            default: begin
            end
         endcase
      end
   end

   // ------------------------------
   // bank selection
   // ------------------------------
   // mode 0: ram bank register drives the upper two rom bank bits
   // mode 1: upper rom bits are zero
   // masking makes small images mirror
   assign rom_bank = {(mode ? 2'b00 : ram_bank_reg), rom_bank_reg} & masks.rom_mask;

   // ram is banked only in mode 1
   assign ram_bank = (mode ? ram_bank_reg : 2'b00) & masks.ram_mask;

   always_comb begin
      if (cart_addr[15:14] == 2'b00) begin
         // fixed bank 0, 16k
         mbc1_bank = {8'd0, cart_addr[13]};
      end else if (cart_addr[15:14] == 2'b01) begin
         // switchable 16k rom bank
         mbc1_bank = {1'b0, rom_bank, cart_addr[13]};
      end else if (region == REGION_CART_RAM) begin
         // 8k ram bank in the ram half of the map
         mbc1_bank = RAM_REGION_BANK + bank_t'(ram_bank);
      end else begin
         mbc1_bank = '0;
      end
   end

   // no mapper: plain 32k linear rom
   assign bank = masks.mbc1 ? mbc1_bank : {7'd0, cart_addr[14:13]};

   // ------------------------------
   // memory request
   // ------------------------------
   always_comb begin
      cart_req.addr  = mem_addr_t'({bank, cart_addr[12:1]});
      // even address is the high byte of the word
      cart_req.lanes = {~cart_addr[0], cart_addr[0]};
      cart_req.wdata = {cart_di, cart_di};
      // only the enabled ram window reaches memory, rom writes are register writes
      cart_req.we    = cart_wr && ram_enable && (region == REGION_CART_RAM);
      cart_req.rd    = cart_rd;
   end

   // remember which byte the last read asked for
   always_ff @(posedge clk64) begin
      if (cart_rd) begin
         a0_q <= cart_addr[0];
      end
   end

   assign cart_do = a0_q ? ram_dout[7:0] : ram_dout[15:8];

   // the cpu side never reads and writes in the same cycle
   cpu_strobes_exclusive: assert property (
      @(posedge clk64) disable iff (reset) !(cart_rd && cart_wr)
   );

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
// memory arbiter
// the download port owns the memory while a download runs,
// otherwise the mapper request goes through untouched
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
   input  logic                clk64,
   input  logic                dl_active,
   input  logic                dl_wr,
   input  cart_pkg::mem_addr_t dl_addr,
   input  cart_pkg::word_t     dl_data,
   input  cart_pkg::mem_req_t  cart_req,
   output cart_pkg::mem_req_t  mem_req
);
   import cart_pkg::*;

   mem_req_t dl_req;

   // download writes whole words, never reads
   always_comb begin
      dl_req.addr  = dl_addr;
      dl_req.wdata = dl_data;
      dl_req.lanes = LANES_BOTH;
      dl_req.we    = dl_wr;
      dl_req.rd    = 1'b0;
   end

   // ------------------------------
   // grant
   // ------------------------------
   // cart requests during a download are dropped, not held
   always_comb begin
      if (dl_active) begin
         mem_req = dl_req;
      end else begin
         mem_req = cart_req;
      end
   end

   // whoever wins, the memory sees one kind of access per cycle
   grant_no_rd_wr: assert property (
      @(posedge clk64) !(mem_req.we && mem_req.rd)
   );

   // a granted write always lands in at least one byte
   grant_wr_has_lanes: assert property (
      @(posedge clk64) mem_req.we |-> (mem_req.lanes != '0)
   );

endmodule

`default_nettype wire

// ==== src/word_ram.sv ====
// cartridge word memory
// synchronous 16-bit ram with byte enables, stands in for the sdram
`timescale 1ns/1ps
`default_nettype none

module word_ram (
   input  logic               clk64,
   input  cart_pkg::mem_req_t mem_req,
   output cart_pkg::word_t    dout
);
   import cart_pkg::*;

   word_t                    mem [2**MEM_ADDR_BITS];
   logic [MEM_ADDR_BITS-1:0] waddr;

   // upper map bits are not decoded
   assign waddr = mem_req.addr[MEM_ADDR_BITS-1:0];

   // ------------------------------
   // write port
   // ------------------------------
   always_ff @(posedge clk64) begin
      if (mem_req.we) begin
         if (mem_req.lanes[1]) begin
            mem[waddr][15:8] <= mem_req.wdata[15:8];
         end
         if (mem_req.lanes[0]) begin
            mem[waddr][7:0] <= mem_req.wdata[7:0];
         end
      end
   end

   // registered read, dout holds until the next read strobe
   always_ff @(posedge clk64) begin
      if (mem_req.rd) begin
         dout <= mem[waddr];
      end
   end

endmodule

`default_nettype wire

// ==== tb/cart_mem_tb.sv ====
// cartridge memory path testbench
// random images through the download port, then random cpu reads and writes,
// checked against a word memory and MBC1 register model
`timescale 1ns/1ps
`default_nettype none

module cart_mem_tb;
   import cart_pkg::*;

   // only the first words of each 4k word block are loaded and touched
   localparam int BLOCK_WORDS = 16;
   localparam int RUN_LIMIT   = 200000;
   localparam int IDLE_LIMIT  = 64;

   logic       clk64 = 1'b0;
   logic       reset;
   logic       dl_active;
   logic       dl_wr;
   mem_addr_t  dl_addr;
   word_t      dl_data;
   cart_addr_t cart_addr;
   byte_t      cart_di;
   logic       cart_rd;
   logic       cart_wr;
   byte_t      cart_do;

   // ------------------------------
   // model state
   // ------------------------------
   // memory indexed by {bank field, word within block}
   word_t      model_mem [0:8191];
   logic       m_mbc1;
   int         m_rom_banks;
   int         m_ram_banks;
   logic [4:0] m_rom_lo;
   logic [1:0] m_bank2;
   logic       m_ram_en;
   logic       m_mode;

   cart_mem_top dut0 (
      .clk64     (clk64),
      .reset     (reset),
      .dl_active (dl_active),
      .dl_wr     (dl_wr),
      .dl_addr   (dl_addr),
      .dl_data   (dl_data),
      .cart_addr (cart_addr),
      .cart_di   (cart_di),
      .cart_rd   (cart_rd),
      .cart_wr   (cart_wr),
      .cart_do   (cart_do)
   );

   always #10 clk64 = ~clk64;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %02h expected %02h", $time, name, got, exp);
         abort_run("read byte differs from the model");
      end
   endtask

   task automatic idle_cycles(input int n);
      int i;
      if (n > IDLE_LIMIT) begin
         abort_run("idle wait is longer than its timeout");
      end
      for (i = 0; i < n; i++) begin
         @(posedge clk64);
      end
   endtask

   // bank field that a cpu address lands in
   // the bank counts give the mirroring
   function automatic int model_bank(input cart_addr_t a);
      int rom_num;
      int ram_num;
      if (!m_mbc1) begin
         return int'(a[14:13]);
      end
      if (a < 16'h4000) begin
         return int'(a[13]);
      end
      if (a < 16'h8000) begin
         // mode 1 drops the two upper rom bank bits
         rom_num = m_mode ? int'(m_rom_lo) : int'({m_bank2, m_rom_lo});
         return (rom_num % m_rom_banks) * 2 + int'(a[13]);
      end
      ram_num = m_mode ? int'(m_bank2) : 0;
      return 256 + (ram_num % m_ram_banks);
   endfunction

   function automatic int model_index(input cart_addr_t a);
      return model_bank(a) * BLOCK_WORDS + int'(a[4:1]);
   endfunction

   function automatic cart_addr_t rom_addr(input logic [1:0] quarter);
      return {quarter, 1'($urandom), 8'd0, 5'($urandom)};
   endfunction

   function automatic cart_addr_t ram_addr();
      return {3'b101, 8'd0, 5'($urandom)};
   endfunction

   // ------------------------------
   // bus tasks
   // ------------------------------
   task automatic dl_word(input int addr, input word_t data);
      @(posedge clk64);
      dl_wr   <= 1'b1;
      dl_addr <= mem_addr_t'(addr);
      dl_data <= data;
   endtask

   task automatic dl_block(input int bank);
      int w;
      word_t data;
      for (w = 0; w < BLOCK_WORDS; w++) begin
         data = word_t'($urandom);
         model_mem[bank * BLOCK_WORDS + w] = data;
         dl_word(bank * 4096 + w, data);
      end
   endtask

   // whole download with the header words last
   // mapper registers go back to reset values
   task automatic dl_image(input byte_t mbc_type, input byte_t rom_code, input byte_t ram_code);
      int b;
      m_mbc1      = (mbc_type >= 8'd1) && (mbc_type <= 8'd3);
      m_rom_banks = (rom_code > 8'd6) ? 128 : (2 << rom_code);
      m_ram_banks = ((ram_code == 8'd1) || (ram_code == 8'd2)) ? 1 : 4;
      m_rom_lo    = 5'd1;
      m_bank2     = 2'd0;
      m_ram_en    = 1'b0;
      m_mode      = 1'b0;
      @(posedge clk64);
      dl_active <= 1'b1;
      for (b = 0; b < (m_mbc1 ? 2 * m_rom_banks : 4); b++) begin
         dl_block(b);
      end
      for (b = 256; m_mbc1 && (b < 260); b++) begin
         dl_block(b);
      end
      dl_word(int'(HDR_TYPE_WORD), {8'($urandom), mbc_type});
      dl_word(int'(HDR_SIZE_WORD), {rom_code, ram_code});
      @(posedge clk64);
      dl_wr     <= 1'b0;
      dl_active <= 1'b0;
   endtask

   task automatic cpu_write(input cart_addr_t a, input byte_t d);
      int idx;
      idx = model_index(a);
      @(posedge clk64);
      cart_wr   <= 1'b1;
      cart_addr <= a;
      cart_di   <= d;
      @(posedge clk64);
      cart_wr <= 1'b0;
      case (a[15:13])
         3'd0: m_ram_en = (d[3:0] == 4'ha);
         3'd1: m_rom_lo = (d[4:0] == 5'd0) ? 5'd1 : d[4:0];
         3'd2: m_bank2 = d[1:0];
         3'd3: m_mode = d[0];
         3'd5: begin
            if (m_ram_en && a[0]) begin
               model_mem[idx][7:0] = d;
            end else if (m_ram_en) begin
               model_mem[idx][15:8] = d;
            end
         end
         default: begin
         end
      endcase
   endtask

   task automatic cpu_read(input cart_addr_t a);
      word_t w;
      w = model_mem[model_index(a)];
      @(posedge clk64);
      cart_rd   <= 1'b1;
      cart_addr <= a;
      @(posedge clk64);
      cart_rd <= 1'b0;
      // word arrives one edge after the strobe and is stable by the falling edge
      @(negedge clk64);
      check_byte("cart_do", cart_do, a[0] ? w[7:0] : w[15:8]);
   endtask

   // new ram bank, a write, its read-back and one more random read
   task automatic ram_traffic(input int n);
      int i;
      cart_addr_t a;
      for (i = 0; i < n; i++) begin
         a = ram_addr();
         cpu_write(16'h4000 | cart_addr_t'($urandom & 32'h1fff), byte_t'($urandom));
         cpu_write(a, byte_t'($urandom));
         cpu_read(a);
         cpu_read(ram_addr());
      end
   endtask

   // ------------------------------
   // stimulus
   // ------------------------------
   initial begin
      int code;
      byte_t v;
      void'($urandom(79698));
      reset     <= 1'b1;
      dl_active <= 1'b0;
      dl_wr     <= 1'b0;
      dl_addr   <= '0;
      dl_data   <= '0;
      cart_addr <= '0;
      cart_di   <= '0;
      cart_rd   <= 1'b0;
      cart_wr   <= 1'b0;
      idle_cycles(2);
      reset <= 1'b0;

      // no mapper means 32k linear
      dl_image(8'd0, 8'd0, 8'd0);
      repeat (40) cpu_read(rom_addr({1'b0, 1'($urandom)}));

      // rom banking over all sizes with bank 0 written now and then
      for (code = 1; code <= 6; code++) begin
         dl_image(8'd1, byte_t'(code), 8'd0);
         repeat (10) begin
            v = (($urandom % 4) == 0) ? 8'd0 : byte_t'($urandom);
            cpu_write(16'h2000 | cart_addr_t'($urandom & 32'h1fff), v);
            cpu_read(rom_addr(2'b01));
            cpu_read(rom_addr(2'b01));
            cpu_read(rom_addr(2'b00));
         end
      end

      // mode 0 upper rom bits, then mode 1 ram banks, then a one bank ram
      dl_image(8'd3, 8'd6, 8'd3);
      repeat (10) begin
         cpu_write(16'h4000, byte_t'($urandom));
         cpu_write(16'h2000, byte_t'($urandom));
         cpu_read(rom_addr(2'b01));
         cpu_read(rom_addr(2'b01));
      end
      ram_traffic(4);
      // nonzero ram bank so mode 1 has upper rom bits to drop
      cpu_write(16'h4000, 8'h02);
      cpu_write(16'h6000, 8'h01);
      cpu_read(rom_addr(2'b01));
      cpu_write(16'h0000, 8'h0a);
      ram_traffic(16);
      // disable value then gated writes
      v = byte_t'($urandom);
      v[3:0] = (v[3:0] == 4'ha) ? 4'h5 : v[3:0];
      cpu_write(16'h1000, v);
      ram_traffic(8);
      dl_image(8'd2, 8'd2, 8'd2);
      cpu_write(16'h6000, 8'h01);
      cpu_write(16'h0000, 8'h1a);
      ram_traffic(12);

      // leave banks and mode set so the new download has to clear them
      cpu_write(16'h2000, 8'h13);
      cpu_write(16'h4000, 8'h02);
      dl_image(8'd1, 8'd5, 8'd3);
      repeat (6) cpu_read(rom_addr(2'b01));
      ram_traffic(2);

      idle_cycles(2);
      $display("Regression passed");
      $finish;
   end

   // watchdog
   initial begin
      int cyc;
      for (cyc = 0; cyc < RUN_LIMIT; cyc++) begin
         @(posedge clk64);
      end
      abort_run("timeout, the run did not finish within the cycle limit");
   end

endmodule

`default_nettype wire
